/* include/tcdm_defs.svh */
/*
 * Cluster geometry and address field layout for the tile remote port.
 * Fields from LSB upward: byte offset, bank, tile in group, group, row.
 * Group and tile counts are assumed to be powers of two.
 */
`ifndef TCDM_DEFS_SVH
`define TCDM_DEFS_SVH

// Cluster geometry
`define TCDM_NUM_GROUPS 4
`define TCDM_NUM_TILES_PER_GROUP 4
`define TCDM_NUM_TILES (`TCDM_NUM_GROUPS * `TCDM_NUM_TILES_PER_GROUP)
`define TCDM_NUM_BANKS_PER_TILE 16

// Address and data sizes
`define TCDM_BYTE_OFFSET 2
`define TCDM_ADDR_WIDTH 32
`define TCDM_ROW_WIDTH 8
`define TCDM_DATA_WIDTH 32

// Index width that never collapses to zero bits
`define TCDM_IDX_WIDTH(n) (((n) > 1) ? $clog2(n) : 1)

// Raw field widths inside the byte address
`define TCDM_BANK_BITS ($clog2(`TCDM_NUM_BANKS_PER_TILE))
`define TCDM_TILE_BITS ($clog2(`TCDM_NUM_TILES_PER_GROUP))
`define TCDM_GROUP_BITS ($clog2(`TCDM_NUM_GROUPS))

// Identifier widths, tile ID is {group, tile in group}
`define TCDM_TILE_ID_WIDTH (`TCDM_IDX_WIDTH(`TCDM_NUM_TILES))
`define TCDM_GROUP_ID_WIDTH (`TCDM_IDX_WIDTH(`TCDM_NUM_GROUPS))

// Field positions
`define TCDM_BANK_LSB (`TCDM_BYTE_OFFSET)
`define TCDM_TILE_LSB (`TCDM_BANK_LSB + `TCDM_BANK_BITS)
`define TCDM_GROUP_LSB (`TCDM_TILE_LSB + `TCDM_TILE_BITS)
`define TCDM_ROW_LSB (`TCDM_GROUP_LSB + `TCDM_GROUP_BITS)

// Tile memory address as seen by a remote tile: {row, bank, tile in group}
`define TCDM_TCDM_ADDR_WIDTH (`TCDM_ROW_WIDTH + `TCDM_BANK_BITS + `TCDM_TILE_BITS)

// Local bank port address: {row, bank}
`define TCDM_LOCAL_ADDR_WIDTH (`TCDM_ROW_WIDTH + `TCDM_BANK_BITS)

`endif

/* hdl/tcdm_addr_pkg.sv */
/*
 * Address-side types of the tile remote port.
 * Widths follow the geometry macros in tcdm_defs.svh.
 */
`default_nettype none

`include "tcdm_defs.svh"

package tcdm_addr_pkg;

  // Byte address as issued by a core
  typedef logic [`TCDM_ADDR_WIDTH-1:0] addr_t;

  // Tile identifier, {group, tile in group}
  typedef logic [`TCDM_TILE_ID_WIDTH-1:0] tile_id_t;

  // Group identifier, doubles as the remote port select
  typedef logic [`TCDM_GROUP_ID_WIDTH-1:0] group_id_t;

  // Address seen by the remote tiles, group field removed
  typedef logic [`TCDM_TCDM_ADDR_WIDTH-1:0] tcdm_addr_t;

  // Address seen by the local banks
  typedef logic [`TCDM_LOCAL_ADDR_WIDTH-1:0] local_addr_t;

endpackage : tcdm_addr_pkg

`default_nettype wire

/* hdl/tcdm_req_pkg.sv */
/*
 * Request payload types and the configuration register map.
 * Offset 3 of the register map is unused and reads as zero.
 */
`default_nettype none

`include "tcdm_defs.svh"

package tcdm_req_pkg;

  // Write data and byte strobes
  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] strb_t;

  // Configuration port
  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  // Register offsets
  localparam cfg_addr_t CfgTileId = 2'd0;
  localparam cfg_addr_t CfgPortEn = 2'd1;
  localparam cfg_addr_t CfgDropCnt = 2'd2;

  // Drop counter stops here
  localparam cfg_data_t DropCntMax = 8'hff;

endpackage : tcdm_req_pkg

`default_nettype wire

/* hdl/tcdm_addr_slicer.sv */
/*
 * Splits a byte address into the tile memory address and remote port select.
 * Purely combinational. The select is target group XOR issuing group,
 * so port 0 always addresses the issuer's own group.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defs.svh"

module tcdm_addr_slicer
  import tcdm_addr_pkg::*;
(
  input  addr_t      remote_req_tgt_addr_i,
  input  group_id_t  group_id_i,
  output tcdm_addr_t remote_req_tgt_addr_o,
  output group_id_t  remote_req_tgt_sel_o
);

  logic [`TCDM_ROW_WIDTH-1:0] row_addr;
  logic [`TCDM_BANK_BITS-1:0] bank_addr;

  // Row and bank are kept in every geometry
  assign row_addr = remote_req_tgt_addr_i[`TCDM_ROW_LSB +: `TCDM_ROW_WIDTH];
  assign bank_addr = remote_req_tgt_addr_i[`TCDM_BANK_LSB +: `TCDM_BANK_BITS];

  // Remote address
  if (`TCDM_NUM_TILES_PER_GROUP == 1) begin : gen_tgt_addr
    // No tile field, only row and bank remain
    assign remote_req_tgt_addr_o = tcdm_addr_t'({row_addr, bank_addr});
  end else begin : gen_tgt_addr
    logic [`TCDM_TILE_BITS-1:0] g_tile_addr;

    // Tile in group moves below the row, group index is dropped
    assign g_tile_addr = remote_req_tgt_addr_i[`TCDM_TILE_LSB +: `TCDM_TILE_BITS];
    assign remote_req_tgt_addr_o = {row_addr, bank_addr, g_tile_addr};
  end

  // Remote port select
  if (`TCDM_NUM_GROUPS == 1) begin : gen_tgt_sel
    // Single group, everything leaves on port 0
    assign remote_req_tgt_sel_o = '0;
  end else begin : gen_tgt_sel
    group_id_t g_addr;

    assign g_addr = remote_req_tgt_addr_i[`TCDM_GROUP_LSB +: `TCDM_GROUP_BITS];
    // Relative group distance picks the port
    assign remote_req_tgt_sel_o = g_addr ^ group_id_i;
  end

endmodule : tcdm_addr_slicer

`default_nettype wire

/* hdl/tile_remote_cfg.sv */
/*
 * Configuration registers beside the request router.
 * Writes land at the sampling edge; readback is combinational.
 * Any write to the drop count clears it, and the count saturates at 255.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defs.svh"

module tile_remote_cfg
  import tcdm_addr_pkg::*;
  import tcdm_req_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        cfg_we_i,
  input  cfg_addr_t                   cfg_addr_i,
  input  cfg_data_t                   cfg_wdata_i,
  input  logic                        drop_i,
  output cfg_data_t                   cfg_rdata_o,
  output tile_id_t                    tile_id_o,
  output logic [`TCDM_NUM_GROUPS-1:0] port_en_o
);

  tile_id_t tile_id_q;
  logic [`TCDM_NUM_GROUPS-1:0] port_en_q;
  cfg_data_t drop_cnt_q;
  logic drop_clr;

  assign drop_clr = cfg_we_i && (cfg_addr_i == CfgDropCnt);

  // Tile ID and port enable mask
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tile_id_q <= '0;
      port_en_q <= '1;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CfgTileId: tile_id_q <= cfg_wdata_i[$bits(tile_id_t)-1:0];
        CfgPortEn: port_en_q <= cfg_wdata_i[`TCDM_NUM_GROUPS-1:0];
        default: ;
      endcase
    end
  end

  // Drop counter, clear wins over increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      drop_cnt_q <= '0;
    end else if (drop_clr) begin
      drop_cnt_q <= '0;
    end else if (drop_i && (drop_cnt_q != DropCntMax)) begin
      drop_cnt_q <= drop_cnt_q + 8'd1;
    end
  end

  // Readback mux
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      CfgTileId: cfg_rdata_o = cfg_data_t'(tile_id_q);
      CfgPortEn: cfg_rdata_o = cfg_data_t'(port_en_q);
      CfgDropCnt: cfg_rdata_o = drop_cnt_q;
      default: cfg_rdata_o = '0;
    endcase
  end

  assign tile_id_o = tile_id_q;
  assign port_en_o = port_en_q;

endmodule : tile_remote_cfg

`default_nettype wire

/* hdl/tcdm_req_router.sv */
/*
 * Routes each request to the local bank port, a remote port, or drops it.
 * One cycle latency, one request per cycle, no back-pressure.
 * drop_o is combinational and lines up with the request being sampled.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defs.svh"

module tcdm_req_router
  import tcdm_addr_pkg::*;
  import tcdm_req_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Incoming request
  input  logic                        req_valid_i,
  input  addr_t                       req_addr_i,
  input  logic                        req_wen_i,
  input  data_t                       req_wdata_i,
  input  strb_t                       req_be_i,
  // Configuration
  input  tile_id_t                    tile_id_i,
  input  logic [`TCDM_NUM_GROUPS-1:0] port_en_i,
  // Local bank port
  output logic                        local_valid_o,
  output local_addr_t                 local_addr_o,
  output logic                        local_wen_o,
  output data_t                       local_wdata_o,
  output strb_t                       local_be_o,
  // Remote port
  output logic                        remote_valid_o,
  output group_id_t                   remote_sel_o,
  output tcdm_addr_t                  remote_addr_o,
  output logic                        remote_wen_o,
  output data_t                       remote_wdata_o,
  output strb_t                       remote_be_o,
  // Discarded request
  output logic                        drop_o
);

  group_id_t own_group;
  logic [`TCDM_TILE_BITS-1:0] own_tile;
  logic [`TCDM_TILE_BITS-1:0] tgt_tile;
  tcdm_addr_t tgt_addr;
  group_id_t tgt_sel;
  logic is_local;
  logic is_remote;
  logic local_valid_q;
  logic remote_valid_q;

  // Split own tile ID into group and tile in group
  assign own_group = tile_id_i[`TCDM_TILE_ID_WIDTH-1 -: `TCDM_GROUP_BITS];
  assign own_tile = tile_id_i[`TCDM_TILE_BITS-1:0];

  tcdm_addr_slicer i_tcdm_addr_slicer (
    .remote_req_tgt_addr_i (req_addr_i),
    .group_id_i            (own_group),
    .remote_req_tgt_addr_o (tgt_addr),
    .remote_req_tgt_sel_o  (tgt_sel)
  );

  // Local when the target sits in our group (select 0) and on our tile
  assign tgt_tile = req_addr_i[`TCDM_TILE_LSB +: `TCDM_TILE_BITS];
  assign is_local = (tgt_sel == '0) && (tgt_tile == own_tile);
  assign is_remote = !is_local && port_en_i[tgt_sel];

  // Disabled port swallows the request
  assign drop_o = req_valid_i && !is_local && !port_en_i[tgt_sel];

  // Valid strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      local_valid_q <= 1'b0;
      remote_valid_q <= 1'b0;
    end else begin
      local_valid_q <= req_valid_i && is_local;
      remote_valid_q <= req_valid_i && is_remote;
    end
  end

  // Local payload, held until the next local request
  always_ff @(posedge clk_i) begin
    if (req_valid_i && is_local) begin
      local_addr_o <= tgt_addr[$bits(tcdm_addr_t)-1 -: $bits(local_addr_t)];
      local_wen_o <= req_wen_i;
      local_wdata_o <= req_wdata_i;
      local_be_o <= req_be_i;
    end
  end

  // Remote payload, held until the next remote request
  always_ff @(posedge clk_i) begin
    if (req_valid_i && is_remote) begin
      remote_sel_o <= tgt_sel;
      remote_addr_o <= tgt_addr;
      remote_wen_o <= req_wen_i;
      remote_wdata_o <= req_wdata_i;
      remote_be_o <= req_be_i;
    end
  end

  assign local_valid_o = local_valid_q;
  assign remote_valid_o = remote_valid_q;

endmodule : tcdm_req_router

`default_nettype wire

/* hdl/tcdm_tile_remote_top.sv */
/*
 * Remote request port of one tile: config registers plus router.
 * Requests are single-cycle strobes; outputs follow one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_defs.svh"

module tcdm_tile_remote_top
  import tcdm_addr_pkg::*;
  import tcdm_req_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Request
  input  logic        req_valid_i,
  input  addr_t       req_addr_i,
  input  logic        req_wen_i,
  input  data_t       req_wdata_i,
  input  strb_t       req_be_i,
  // Configuration
  input  logic        cfg_we_i,
  input  cfg_addr_t   cfg_addr_i,
  input  cfg_data_t   cfg_wdata_i,
  output cfg_data_t   cfg_rdata_o,
  // Local bank port
  output logic        local_valid_o,
  output local_addr_t local_addr_o,
  output logic        local_wen_o,
  output data_t       local_wdata_o,
  output strb_t       local_be_o,
  // Remote port
  output logic        remote_valid_o,
  output group_id_t   remote_sel_o,
  output tcdm_addr_t  remote_addr_o,
  output logic        remote_wen_o,
  output data_t       remote_wdata_o,
  output strb_t       remote_be_o
);

  tile_id_t tile_id;
  logic [`TCDM_NUM_GROUPS-1:0] port_en;
  logic drop;

  tile_remote_cfg i_tile_remote_cfg (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .drop_i      (drop),
    .cfg_rdata_o (cfg_rdata_o),
    .tile_id_o   (tile_id),
    .port_en_o   (port_en)
  );

  tcdm_req_router i_tcdm_req_router (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_wen_i      (req_wen_i),
    .req_wdata_i    (req_wdata_i),
    .req_be_i       (req_be_i),
    .tile_id_i      (tile_id),
    .port_en_i      (port_en),
    .local_valid_o  (local_valid_o),
    .local_addr_o   (local_addr_o),
    .local_wen_o    (local_wen_o),
    .local_wdata_o  (local_wdata_o),
    .local_be_o     (local_be_o),
    .remote_valid_o (remote_valid_o),
    .remote_sel_o   (remote_sel_o),
    .remote_addr_o  (remote_addr_o),
    .remote_wen_o   (remote_wen_o),
    .remote_wdata_o (remote_wdata_o),
    .remote_be_o    (remote_be_o),
    .drop_o         (drop)
  );

endmodule : tcdm_tile_remote_top

`default_nettype wire

/* test/tb_tcdm_tile_remote.sv */
/*
 * Testbench for the tile remote request port.
 * Expected values assume 4 groups of 4 tiles, 16 banks and 256 rows per bank.
 * Each step is checked one cycle after it is driven.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tcdm_tile_remote
  import tcdm_req_pkg::*;
();

  localparam int ClkPeriod = 40;
  localparam int ResetCycles = 10;
  localparam int NumRandom = 200;
  localparam logic [31:0] LfsrSeed = 32'h0c77_eb2c;

  // Step kinds
  localparam logic [1:0] KindWr = 2'd0;
  localparam logic [1:0] KindRd = 2'd1;
  localparam logic [1:0] KindReq = 2'd2;
  localparam logic [1:0] KindIdle = 2'd3;

  // Expected routes
  localparam logic [1:0] RouteLocal = 2'd0;
  localparam logic [1:0] RouteRemote = 2'd1;
  localparam logic [1:0] RouteDrop = 2'd2;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic req_valid_i;
  logic [31:0] req_addr_i;
  logic req_wen_i;
  logic [31:0] req_wdata_i;
  logic [3:0] req_be_i;
  logic cfg_we_i;
  logic [1:0] cfg_addr_i;
  logic [7:0] cfg_wdata_i;
  logic [7:0] cfg_rdata_o;
  logic local_valid_o;
  logic [11:0] local_addr_o;
  logic local_wen_o;
  logic [31:0] local_wdata_o;
  logic [3:0] local_be_o;
  logic remote_valid_o;
  logic [1:0] remote_sel_o;
  logic [13:0] remote_addr_o;
  logic remote_wen_o;
  logic [31:0] remote_wdata_o;
  logic [3:0] remote_be_o;

  // Step layout {kind, cfg addr, cfg data or expected readback, req addr, wen, wdata, strobes,
  // expected route, expected select, expected address}
  logic [98:0] steps[$];

  // Step driven one cycle ago and checked on the next falling edge
  logic [1:0] pend_kind = KindIdle;
  logic [1:0] pend_cfg_addr;
  logic [7:0] pend_cfg_data;
  logic [31:0] pend_addr;
  logic pend_wen;
  logic [31:0] pend_wdata;
  logic [3:0] pend_be;
  logic [1:0] pend_route;
  logic [1:0] pend_sel;
  logic [13:0] pend_exp;

  // Reference model state
  logic [3:0] model_tile_id = 4'h0;
  logic [3:0] model_port_en = 4'hf;
  logic [7:0] model_drop_cnt = 8'h00;
  logic [31:0] lfsr_state;
  logic table_built = 1'b0;

  tcdm_tile_remote_top i_tcdm_tile_remote_top (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // Predicts {route, select, address} in routing rule order
  function automatic logic [17:0] predict_route(input logic [31:0] addr,
                                                input logic [3:0] tile_id,
                                                input logic [3:0] port_en);
    logic [1:0] sel;
    sel = addr[9:8] ^ tile_id[3:2];
    if (addr[9:6] == tile_id) begin
      return {RouteLocal, 2'd0, 2'b00, addr[17:10], addr[5:2]};
    end else if (port_en[sel]) begin
      return {RouteRemote, sel, addr[17:10], addr[5:2], addr[7:6]};
    end
    return {RouteDrop, sel, 14'h0};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error %s: got 0x%h, expected 0x%h at %0t ns", name, actual, expected, $time);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_pending();
    logic exp_local;
    logic exp_remote;
    exp_local = (pend_kind == KindReq) && (pend_route == RouteLocal);
    exp_remote = (pend_kind == KindReq) && (pend_route == RouteRemote);
    check_value("local_valid_o", local_valid_o, exp_local);
    check_value("remote_valid_o", remote_valid_o, exp_remote);
    if (pend_kind == KindRd) begin
      check_value("cfg_rdata_o", cfg_rdata_o, pend_cfg_data);
    end
    if (exp_local) begin
      check_value("local_addr_o", local_addr_o, pend_exp[11:0]);
      check_value("local_wen_o", local_wen_o, pend_wen);
      check_value("local_wdata_o", local_wdata_o, pend_wdata);
      check_value("local_be_o", local_be_o, pend_be);
    end
    if (exp_remote) begin
      check_value("remote_sel_o", remote_sel_o, pend_sel);
      check_value("remote_addr_o", remote_addr_o, pend_exp);
      check_value("remote_wen_o", remote_wen_o, pend_wen);
      check_value("remote_wdata_o", remote_wdata_o, pend_wdata);
      check_value("remote_be_o", remote_be_o, pend_be);
    end
  endtask

  // Checks the previous step and drives this one on the falling edge
  task automatic apply_step(input logic [98:0] step);
    @(negedge clk_i);
    check_pending();
    {pend_kind, pend_cfg_addr, pend_cfg_data, pend_addr, pend_wen, pend_wdata, pend_be,
     pend_route, pend_sel, pend_exp} = step;
    cfg_we_i = (pend_kind == KindWr);
    cfg_addr_i = pend_cfg_addr;
    cfg_wdata_i = pend_cfg_data;
    req_valid_i = (pend_kind == KindReq);
    req_addr_i = pend_addr;
    req_wen_i = pend_wen;
    req_wdata_i = pend_wdata;
    req_be_i = pend_be;
    // Model follows what the DUT sees from the next edge on
    if (pend_kind == KindWr) begin
      case (pend_cfg_addr)
        CfgTileId: model_tile_id = pend_cfg_data[3:0];
        CfgPortEn: model_port_en = pend_cfg_data[3:0];
        CfgDropCnt: model_drop_cnt = 8'h00;
        default: ;
      endcase
    end
    if ((pend_kind == KindReq) && (pend_route == RouteDrop) && (model_drop_cnt != 8'hff)) begin
      model_drop_cnt = model_drop_cnt + 8'd1;
    end
  endtask

  task automatic add_cfg(input logic [1:0] kind, input logic [1:0] addr, input logic [7:0] value);
    steps.push_back({kind, addr, value, 87'h0});
  endtask

  task automatic add_req(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                         input logic [3:0] be, input logic [1:0] route, input logic [1:0] sel,
                         input logic [13:0] exp_addr);
    steps.push_back({KindReq, 2'd0, 8'h00, addr, wen, wdata, be, route, sel, exp_addr});
  endtask

  task automatic build_table();
    // Reset values
    add_cfg(KindRd, CfgTileId, 8'h00);
    add_cfg(KindRd, CfgPortEn, 8'h0f);
    add_cfg(KindRd, CfgDropCnt, 8'h00);
    // Tile 6 is group 1 and tile 2
    add_cfg(KindWr, CfgTileId, 8'h06);
    add_cfg(KindRd, CfgTileId, 8'h06);
    // Local then remote back to back with upper address bits set
    add_req(32'h8002_958c, 1'b1, 32'hdead_beef, 4'hf, RouteLocal, 2'd0, 14'h0a53);
    add_req(32'h0000_4b3c, 1'b0, 32'h0123_4567, 4'h3, RouteRemote, 2'd2, 14'h04bc);
    add_req(32'h0003_fdc0, 1'b1, 32'hcafe_f00d, 4'h5, RouteRemote, 2'd0, 14'h3fc3);
    add_req(32'h0000_f09c, 1'b0, 32'h55aa_55aa, 4'hc, RouteRemote, 2'd1, 14'h0f1e);
    add_req(32'h0000_05bb, 1'b0, 32'h0bad_c0de, 4'h1, RouteLocal, 2'd0, 14'h001e);
    // Port 2 disabled
    add_cfg(KindWr, CfgPortEn, 8'h0b);
    add_cfg(KindRd, CfgPortEn, 8'h0b);
    add_req(32'h0001_0348, 1'b1, 32'h1111_1111, 4'hf, RouteDrop, 2'd2, 14'h0000);
    add_req(32'h0001_ffe4, 1'b0, 32'h2222_2222, 4'h3, RouteDrop, 2'd2, 14'h0000);
    add_cfg(KindRd, CfgDropCnt, 8'h02);
    add_req(32'h0000_2204, 1'b1, 32'h3333_3333, 4'hf, RouteRemote, 2'd3, 14'h0204);
    add_req(32'h0000_0300, 1'b0, 32'h4444_4444, 4'h0, RouteDrop, 2'd2, 14'h0000);
    add_cfg(KindRd, CfgDropCnt, 8'h03);
    // Unused offset reads as zero
    add_cfg(KindRd, 2'd3, 8'h00);
    // Any write clears the counter
    add_cfg(KindWr, CfgDropCnt, 8'h5a);
    add_cfg(KindRd, CfgDropCnt, 8'h00);
    add_cfg(KindWr, CfgPortEn, 8'h0f);
    add_req(32'h0001_0348, 1'b1, 32'h6666_6666, 4'ha, RouteRemote, 2'd2, 14'h1009);
    add_cfg(KindRd, CfgDropCnt, 8'h00);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] wen_bit;
    logic [31:0] strobe;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    req_wen_i = 1'b0;
    req_wdata_i = '0;
    req_be_i = '0;
    cfg_we_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    lfsr_state = LfsrSeed;
    build_table();
    table_built = 1'b1;
    repeat (ResetCycles) @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
    end

    for (int n = 0; n < NumRandom; n++) begin
      draw_bits(4, r);
      if (r[3:0] == 4'h0) begin
        // Occasional change of tile ID or port mask
        draw_bits(1, r);
        draw_bits(8, wdata);
        apply_step({KindWr, (r[0] ? CfgPortEn : CfgTileId), wdata[7:0], 87'h0});
      end else begin
        draw_bits(32, addr);
        draw_bits(2, r);
        // Steer a quarter of the requests to our own tile
        if (r[1:0] == 2'b00) begin
          addr[9:6] = model_tile_id;
        end
        draw_bits(1, wen_bit);
        draw_bits(32, wdata);
        draw_bits(4, strobe);
        apply_step({KindReq, 2'd0, 8'h00, addr, wen_bit[0], wdata, strobe[3:0],
                    predict_route(addr, model_tile_id, model_port_en)});
      end
    end

    // Final register state against the model
    apply_step({KindRd, CfgTileId, 4'h0, model_tile_id, 87'h0});
    apply_step({KindRd, CfgPortEn, 4'h0, model_port_en, 87'h0});
    apply_step({KindRd, CfgDropCnt, model_drop_cnt, 87'h0});
    apply_step({KindIdle, 97'h0});
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_built);
    #((steps.size() + NumRandom + 50) * ClkPeriod);
    $display("Timeout: the run did not finish within the expected number of cycles");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule : tb_tcdm_tile_remote

`default_nettype wire

/* sources.f */
+incdir+include
hdl/tcdm_addr_pkg.sv
hdl/tcdm_req_pkg.sv
hdl/tcdm_addr_slicer.sv
hdl/tile_remote_cfg.sv
hdl/tcdm_req_router.sv
hdl/tcdm_tile_remote_top.sv
test/tb_tcdm_tile_remote.sv
